//--- rv_cfg.svh
// Core-wide constants for the RV32I multi-cycle core
// Lane logic in mem_access assumes a 32-bit word with 4 byte strobes
// RV_RESET_PC must be word aligned
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ==============================
// Widths
// ==============================
`define RV_XLEN     32
`define RV_REG_AW   5

// ==============================
// Reset
// ==============================
`define RV_RESET_PC 32'h0000_0000

`endif

//--- rv_pkg.sv
// Types shared between the stages of the multi-cycle core
// Struct widths follow the constants in rv_cfg.svh
`include "rv_cfg.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LINK,   // PC + 4 for JAL/JALR
        WB_IMM,    // LUI
        WB_LOAD
    } wb_sel_t;

    // Encodings match funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MW_BYTE = 2'b00,
        MW_HALF = 2'b01,
        MW_WORD = 2'b10
    } mem_width_t;

    // Decoder output, combinational from the instruction register
    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm;
        alu_op_t               alu_op;
        logic                  op_a_pc;    // Operand A is the PC
        logic                  op_b_imm;   // Operand B is the immediate
        wb_sel_t               wb_sel;
        logic                  reg_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic [2:0]            br_funct3;
        mem_width_t            mem_width;
        logic                  mem_unsigned;
    } decoded_t;

    // Latched at the end of EXECUTE, held through WRITEBACK
    typedef struct packed {
        logic [`RV_XLEN-1:0]   value;        // Result, or address for loads/stores
        logic [`RV_XLEN-1:0]   store_data;
        logic [`RV_XLEN-1:0]   next_pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_we;
        logic                  use_load;
        logic                  is_load;
        logic                  is_store;
        mem_width_t            mem_width;
        logic                  mem_unsigned;
    } ex_result_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
        logic                  we;
    } reg_write_t;

endpackage

//--- core_sequencer.sv
// Phase FSM for the non-pipelined core
// A transfer completing in FETCH or MEMORY skips the wait state

module core_sequencer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_done,
    input  logic             mem_done,
    input  rv_pkg::decoded_t dec,
    output logic             fetch_en,
    output logic             exec_en,
    output logic             mem_en,
    output logic             wb_en
);

    typedef enum logic [2:0] {
        RESET,
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEMORY,
        MEMORY_WAIT,
        WRITEBACK
    } state_t;

    state_t state, state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RESET;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RESET:       state_nxt = FETCH;
            FETCH:       state_nxt = fetch_done ? EXECUTE : FETCH_WAIT;
            FETCH_WAIT:  if (fetch_done) state_nxt = EXECUTE;
            EXECUTE:     state_nxt = (dec.is_load || dec.is_store) ? MEMORY : WRITEBACK;
            MEMORY:      state_nxt = mem_done ? WRITEBACK : MEMORY_WAIT;
            MEMORY_WAIT: if (mem_done) state_nxt = WRITEBACK;
            WRITEBACK:   state_nxt = FETCH;
            default:     state_nxt = RESET;
        endcase
    end

    // Stage strobes
    assign fetch_en = (state == FETCH) || (state == FETCH_WAIT);
    assign exec_en  = (state == EXECUTE);
    assign mem_en   = (state == MEMORY) || (state == MEMORY_WAIT);
    assign wb_en    = (state == WRITEBACK);

endmodule

//--- instr_fetch.sv
// PC and instruction register
// ibus_req and ibus_addr stay steady for the whole fetch phase
`include "rv_cfg.svh"

module instr_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_en,
    input  logic                wb_en,
    input  logic [`RV_XLEN-1:0] next_pc,
    input  logic [`RV_XLEN-1:0] ibus_rdata,
    input  logic                ibus_ready,
    output logic                ibus_req,
    output logic [`RV_XLEN-1:0] ibus_addr,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] instr,
    output logic                fetch_done
);

    assign ibus_req   = fetch_en;
    assign ibus_addr  = pc;
    assign fetch_done = fetch_en & ibus_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= `RV_RESET_PC;
            instr <= '0;          // Decodes as a no-op
        end else begin
            if (fetch_done) begin
                instr <= ibus_rdata;
            end
            if (wb_en) begin
                pc <= next_pc;    // PC moves only at the end of WRITEBACK
            end
        end
    end

endmodule

//--- instr_decode.sv
// Combinational RV32I decoder
// SYSTEM, FENCE and any unknown opcode decode to a no-op
`include "rv_cfg.svh"

module instr_decode (
    input  logic [`RV_XLEN-1:0] instr,
    output rv_pkg::decoded_t    dec
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7b5;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::alu_op_t alu_fn;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign f7b5   = instr[30];

    // ==============================
    // Immediates
    // ==============================
    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // Shared by OP and OP-IMM, SUB only exists in OP
    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (opcode == OPC_OP && f7b5) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_fn = rv_pkg::ALU_SLL;
            3'b010:  alu_fn = rv_pkg::ALU_SLT;
            3'b011:  alu_fn = rv_pkg::ALU_SLTU;
            3'b100:  alu_fn = rv_pkg::ALU_XOR;
            3'b101:  alu_fn = f7b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_fn = rv_pkg::ALU_OR;
            default: alu_fn = rv_pkg::ALU_AND;
        endcase
    end

    // ==============================
    // Control decode
    // ==============================
    always_comb begin
        dec              = '0;
        dec.rd           = instr[11:7];
        dec.rs1          = instr[19:15];
        dec.rs2          = instr[24:20];
        dec.imm          = imm_i;
        dec.alu_op       = rv_pkg::ALU_ADD;
        dec.wb_sel       = rv_pkg::WB_ALU;
        dec.br_funct3    = funct3;
        dec.mem_unsigned = funct3[2];
        case (funct3[1:0])
            2'b00:   dec.mem_width = rv_pkg::MW_BYTE;
            2'b01:   dec.mem_width = rv_pkg::MW_HALF;
            default: dec.mem_width = rv_pkg::MW_WORD;
        endcase

        case (opcode)
            OPC_OP: begin
                dec.alu_op = alu_fn;
                dec.reg_we = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.alu_op   = alu_fn;
                dec.op_b_imm = 1'b1;
                dec.reg_we   = 1'b1;
            end
            OPC_LUI: begin
                dec.imm    = imm_u;
                dec.wb_sel = rv_pkg::WB_IMM;
                dec.reg_we = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm      = imm_u;
                dec.op_a_pc  = 1'b1;
                dec.op_b_imm = 1'b1;
                dec.reg_we   = 1'b1;
            end
            OPC_LOAD: begin
                dec.op_b_imm = 1'b1;   // rs1 + offset
                dec.wb_sel   = rv_pkg::WB_LOAD;
                dec.reg_we   = 1'b1;
                dec.is_load  = 1'b1;
            end
            OPC_STORE: begin
                dec.imm      = imm_s;
                dec.op_b_imm = 1'b1;
                dec.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            OPC_JAL: begin
                dec.imm    = imm_j;
                dec.wb_sel = rv_pkg::WB_LINK;
                dec.reg_we = 1'b1;
                dec.is_jal = 1'b1;
            end
            OPC_JALR: begin
                dec.wb_sel  = rv_pkg::WB_LINK;
                dec.reg_we  = 1'b1;
                dec.is_jalr = 1'b1;
            end
            default: dec.reg_we = 1'b0;
        endcase
    end

endmodule

//--- register_file.sv
// 31 general registers, x0 is hardwired to zero
// Reads are combinational, the write lands at the clock edge
`include "rv_cfg.svh"

module register_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data,
    input  rv_pkg::reg_write_t    wr
);

    logic [`RV_XLEN-1:0] regs [1:(1 << `RV_REG_AW)-1];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << `RV_REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.rd != '0) begin   // x0 writes dropped
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

//--- execute_stage.sv
// Operand select, ALU, branch compare and next PC
// Result is latched on exec_en and held until the next EXECUTE
`include "rv_cfg.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                exec_en,
    input  logic [`RV_XLEN-1:0] pc,
    input  rv_pkg::decoded_t    dec,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output rv_pkg::ex_result_t  res
);

    logic [`RV_XLEN-1:0] op_a, op_b, alu_out, pc_plus4, jalr_tgt;
    logic [4:0]          shamt;
    logic                taken;
    rv_pkg::ex_result_t  res_d;

    assign op_a     = dec.op_a_pc ? pc : rs1_data;
    assign op_b     = dec.op_b_imm ? dec.imm : rs2_data;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + 4;
    assign jalr_tgt = rs1_data + dec.imm;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:  alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_out = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_out = {31'd0, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_out = op_a | op_b;
            default:          alu_out = op_a & op_b;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (dec.br_funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) <  $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data <  rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        res_d              = '0;
        res_d.store_data   = rs2_data;
        res_d.rd           = dec.rd;
        res_d.reg_we       = dec.reg_we;
        res_d.use_load     = (dec.wb_sel == rv_pkg::WB_LOAD);
        res_d.is_load      = dec.is_load;
        res_d.is_store     = dec.is_store;
        res_d.mem_width    = dec.mem_width;
        res_d.mem_unsigned = dec.mem_unsigned;

        case (dec.wb_sel)
            rv_pkg::WB_LINK: res_d.value = pc_plus4;
            rv_pkg::WB_IMM:  res_d.value = dec.imm;
            default:         res_d.value = alu_out;   // Also the load/store address
        endcase

        if (dec.is_jalr) begin
            res_d.next_pc = {jalr_tgt[`RV_XLEN-1:1], 1'b0};
        end else if (dec.is_jal || (dec.is_branch && taken)) begin
            res_d.next_pc = pc + dec.imm;
        end else begin
            res_d.next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else if (exec_en) begin
            res <= res_d;
        end
    end

endmodule

//--- mem_access.sv
// Data bus access, lane alignment and register write
// Misaligned addresses go out unchecked; halves use address bit 1 only
// Assumes a 32-bit word with 4 byte lanes
`include "rv_cfg.svh"

module mem_access (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_en,
    input  logic                wb_en,
    input  rv_pkg::ex_result_t  res,
    input  logic [`RV_XLEN-1:0] dbus_rdata,
    input  logic                dbus_ready,
    output logic                dbus_req,
    output logic                dbus_we,
    output logic [`RV_XLEN-1:0] dbus_addr,
    output logic [`RV_XLEN-1:0] dbus_wdata,
    output logic [3:0]          dbus_wstrb,
    output logic                mem_done,
    output rv_pkg::reg_write_t  wr
);

    logic [1:0]          lane;
    logic [3:0]          strb_base;
    logic [`RV_XLEN-1:0] rdata_q, rshift, load_val;

    // Byte offset of the access within the word
    always_comb begin
        case (res.mem_width)
            rv_pkg::MW_BYTE: begin
                lane      = res.value[1:0];
                strb_base = 4'b0001;
            end
            rv_pkg::MW_HALF: begin
                lane      = {res.value[1], 1'b0};
                strb_base = 4'b0011;
            end
            default: begin
                lane      = 2'b00;
                strb_base = 4'b1111;
            end
        endcase
    end

    assign dbus_req   = mem_en;
    assign dbus_we    = res.is_store;
    assign dbus_addr  = res.value;
    assign dbus_wdata = res.store_data << {lane, 3'b000};   // rs2 into its lanes
    assign dbus_wstrb = strb_base << lane;
    assign mem_done   = mem_en & dbus_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (mem_done && res.is_load) begin
            rdata_q <= dbus_rdata;
        end
    end

    // ==============================
    // Load extraction
    // ==============================
    assign rshift = rdata_q >> {lane, 3'b000};

    always_comb begin
        case (res.mem_width)
            rv_pkg::MW_BYTE:
                load_val = res.mem_unsigned ? {24'h0, rshift[7:0]}
                                            : {{24{rshift[7]}}, rshift[7:0]};
            rv_pkg::MW_HALF:
                load_val = res.mem_unsigned ? {16'h0, rshift[15:0]}
                                            : {{16{rshift[15]}}, rshift[15:0]};
            default: load_val = rshift;
        endcase
    end

    always_comb begin
        wr.rd   = res.rd;
        wr.data = res.use_load ? load_val : res.value;
        wr.we   = wb_en & res.reg_we;   // Single write at the end of WRITEBACK
    end

endmodule

//--- rv_core.sv
// Multi-cycle RV32I core, one instruction in flight
// Both buses complete a transfer when req and ready are high together
// No traps, CSRs or M extension; unknown opcodes run as no-ops
`include "rv_cfg.svh"

module rv_core (
    input  logic               clk,
    input  logic               rst_n,
    // Instruction bus
    output logic               ibus_req,
    output logic [`RV_XLEN-1:0] ibus_addr,
    input  logic [`RV_XLEN-1:0] ibus_rdata,
    input  logic               ibus_ready,
    // Data bus
    output logic               dbus_req,
    output logic               dbus_we,
    output logic [`RV_XLEN-1:0] dbus_addr,
    output logic [`RV_XLEN-1:0] dbus_wdata,
    output logic [3:0]         dbus_wstrb,
    input  logic [`RV_XLEN-1:0] dbus_rdata,
    input  logic               dbus_ready
);

    logic fetch_en, exec_en, mem_en, wb_en;
    logic fetch_done, mem_done;

    logic [`RV_XLEN-1:0] pc, instr;
    logic [`RV_XLEN-1:0] rs1_data, rs2_data;

    rv_pkg::decoded_t   dec;
    rv_pkg::ex_result_t res;
    rv_pkg::reg_write_t wr;

    // ==============================
    // Stages in program order
    // ==============================
    core_sequencer u_sequencer (
        .clk(clk), .rst_n(rst_n),
        .fetch_done(fetch_done), .mem_done(mem_done),
        .dec(dec),
        .fetch_en(fetch_en), .exec_en(exec_en), .mem_en(mem_en), .wb_en(wb_en)
    );

    instr_fetch u_fetch (
        .clk(clk), .rst_n(rst_n),
        .fetch_en(fetch_en), .wb_en(wb_en),
        .next_pc(res.next_pc),
        .ibus_rdata(ibus_rdata), .ibus_ready(ibus_ready),
        .ibus_req(ibus_req), .ibus_addr(ibus_addr),
        .pc(pc), .instr(instr),
        .fetch_done(fetch_done)
    );

    instr_decode u_decode (
        .instr(instr),
        .dec(dec)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(dec.rs1), .rs2_addr(dec.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr(wr)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n),
        .exec_en(exec_en),
        .pc(pc), .dec(dec),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .res(res)
    );

    mem_access u_mem (
        .clk(clk), .rst_n(rst_n),
        .mem_en(mem_en), .wb_en(wb_en),
        .res(res),
        .dbus_rdata(dbus_rdata), .dbus_ready(dbus_ready),
        .dbus_req(dbus_req), .dbus_we(dbus_we), .dbus_addr(dbus_addr),
        .dbus_wdata(dbus_wdata), .dbus_wstrb(dbus_wstrb),
        .mem_done(mem_done),
        .wr(wr)
    );

endmodule

//--- tb_program.svh
// Test program, data memory preload and the expected store table
// Included inside tb_rv_core; fills rom, dmem and the exp_* queues
// The program ends in a JAL to itself at 0x144

// RV32I instruction formats
function automatic logic [31:0] reg_op(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd);
    reg_op = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] imm_op(input int imm, input int rs1, input int f3,
                                       input int rd, input logic [6:0] opc);
    imm_op = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] store_op(input int imm, input int rs2, input int rs1,
                                         input int f3);
    store_op = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] branch_op(input int imm, input int rs1, input int rs2,
                                          input int f3);
    branch_op = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                 7'h63};
endfunction

function automatic logic [31:0] jump_op(input int imm, input int rd);
    jump_op = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
endfunction

task automatic put(input logic [31:0] word);
    rom[rom_fill] = word;
    rom_fill++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_strb.push_back(strb);
endtask

task automatic load_program();
    int i;
    for (i = 0; i < 128; i++) begin
        rom[i] = 32'h0;
    end
    for (i = 0; i < 256; i++) begin
        dmem[i] = 32'h1000_0000 | i;   // Pattern over the whole index
    end
    dmem[64] = 32'h80F1_7F92;          // Load source at 0x100
    rom_fill = 0;
    // ==============================
    // ALU, LUI, AUIPC
    // ==============================
    put(imm_op(256, 0, 0, 1, 7'h13));  // x1 = 0x100
    put(imm_op(512, 0, 0, 2, 7'h13));  // x2 = 0x200 store base
    put(imm_op(-7, 0, 0, 3, 7'h13));
    put(imm_op(5, 0, 0, 4, 7'h13));
    put(reg_op(0, 4, 3, 0, 5));    // add
    put(store_op(0, 5, 2, 2));
    put(reg_op(32, 3, 4, 0, 5));   // sub
    put(store_op(4, 5, 2, 2));
    put(reg_op(0, 4, 4, 1, 5));    // sll
    put(store_op(8, 5, 2, 2));
    put(reg_op(0, 4, 3, 5, 5));    // srl
    put(store_op(12, 5, 2, 2));
    put(reg_op(32, 4, 3, 5, 5));   // sra
    put(store_op(16, 5, 2, 2));
    put(reg_op(0, 4, 3, 2, 5));    // slt
    put(store_op(20, 5, 2, 2));
    put(reg_op(0, 4, 3, 3, 5));    // sltu
    put(store_op(24, 5, 2, 2));
    put(reg_op(0, 4, 3, 4, 5));    // xor
    put(store_op(28, 5, 2, 2));
    put(reg_op(0, 4, 3, 6, 5));    // or
    put(store_op(32, 5, 2, 2));
    put(reg_op(0, 4, 3, 7, 5));    // and
    put(store_op(36, 5, 2, 2));
    put(imm_op('h401, 3, 5, 5, 7'h13));    // srai 1
    put(store_op(40, 5, 2, 2));
    put({20'h12345, 5'd5, 7'h37});         // lui
    put(store_op(44, 5, 2, 2));
    put({20'h00001, 5'd5, 7'h17});         // auipc at 0x70
    put(store_op(48, 5, 2, 2));
    // Loads from 0x100
    put(imm_op(0, 1, 0, 5, 7'h03));  // lb lane 0
    put(store_op(52, 5, 2, 2));
    put(imm_op(1, 1, 0, 5, 7'h03));  // lb lane 1
    put(store_op(56, 5, 2, 2));
    put(imm_op(2, 1, 4, 5, 7'h03));  // lbu lane 2
    put(store_op(60, 5, 2, 2));
    put(imm_op(3, 1, 0, 5, 7'h03));  // lb lane 3
    put(store_op(64, 5, 2, 2));
    put(imm_op(2, 1, 1, 5, 7'h03));  // lh upper half
    put(store_op(68, 5, 2, 2));
    put(imm_op(0, 1, 5, 5, 7'h03));  // lhu lower half
    put(store_op(72, 5, 2, 2));
    put(imm_op(0, 1, 2, 5, 7'h03));  // lw
    put(store_op(76, 5, 2, 2));
    // Narrow stores of x5
    put(store_op(80, 5, 2, 0));
    put(store_op(81, 5, 2, 0));
    put(store_op(82, 5, 2, 0));
    put(store_op(83, 5, 2, 0));
    put(store_op(84, 5, 2, 1));
    put(store_op(86, 5, 2, 1));
    // ==============================
    // Branches, taken ones skip a bad store
    // ==============================
    put(branch_op(8, 4, 4, 0));  // beq
    put(store_op(400, 3, 2, 2));
    put(branch_op(8, 3, 4, 1));  // bne
    put(store_op(400, 3, 2, 2));
    put(branch_op(8, 3, 4, 4));  // blt
    put(store_op(400, 3, 2, 2));
    put(branch_op(8, 4, 3, 5));  // bge
    put(store_op(400, 3, 2, 2));
    put(branch_op(8, 4, 3, 6));  // bltu
    put(store_op(400, 3, 2, 2));
    put(branch_op(8, 3, 4, 7));  // bgeu
    put(store_op(400, 3, 2, 2));
    // Not taken, a wrong turn lands on the trap area at index 82
    put(branch_op(80, 3, 4, 0));
    put(branch_op(76, 4, 4, 1));
    put(branch_op(72, 4, 3, 4));
    put(branch_op(68, 3, 4, 5));
    put(branch_op(64, 3, 4, 6));
    put(branch_op(60, 4, 3, 7));
    put(store_op(88, 4, 2, 2));
    // Jumps
    put(jump_op(8, 6));                    // jal at 0x114
    put(store_op(400, 3, 2, 2));
    put(store_op(92, 6, 2, 2));
    put(imm_op(305, 0, 0, 7, 7'h13));      // Odd target 0x131
    put(imm_op(0, 7, 0, 8, 7'h67));        // jalr at 0x124
    put(store_op(400, 3, 2, 2));
    put(store_op(400, 3, 2, 2));
    put(store_op(96, 8, 2, 2));
    // x0 and no-ops
    put(imm_op(123, 0, 0, 0, 7'h13));
    put(store_op(100, 0, 2, 2));
    put(32'h0000_0073);                    // ecall
    put(store_op(104, 4, 2, 2));
    put(jump_op(0, 0));                    // Final loop at 0x144
    put(store_op(400, 3, 2, 2));           // Trap area
    put(jump_op(0, 0));
endtask

task automatic load_expected();
    expect_store(32'h200, 32'hFFFF_FFFE, 4'hF);
    expect_store(32'h204, 32'h0000_000C, 4'hF);
    expect_store(32'h208, 32'h0000_00A0, 4'hF);
    expect_store(32'h20C, 32'h07FF_FFFF, 4'hF);
    expect_store(32'h210, 32'hFFFF_FFFF, 4'hF);
    expect_store(32'h214, 32'h0000_0001, 4'hF);
    expect_store(32'h218, 32'h0000_0000, 4'hF);
    expect_store(32'h21C, 32'hFFFF_FFFC, 4'hF);
    expect_store(32'h220, 32'hFFFF_FFFD, 4'hF);
    expect_store(32'h224, 32'h0000_0001, 4'hF);
    expect_store(32'h228, 32'hFFFF_FFFC, 4'hF);
    expect_store(32'h22C, 32'h1234_5000, 4'hF);
    expect_store(32'h230, 32'h0000_1070, 4'hF);
    expect_store(32'h234, 32'hFFFF_FF92, 4'hF);
    expect_store(32'h238, 32'h0000_007F, 4'hF);
    expect_store(32'h23C, 32'h0000_00F1, 4'hF);
    expect_store(32'h240, 32'hFFFF_FF80, 4'hF);
    expect_store(32'h244, 32'hFFFF_80F1, 4'hF);
    expect_store(32'h248, 32'h0000_7F92, 4'hF);
    expect_store(32'h24C, 32'h80F1_7F92, 4'hF);
    expect_store(32'h250, 32'h80F1_7F92, 4'h1);
    expect_store(32'h251, 32'hF17F_9200, 4'h2);
    expect_store(32'h252, 32'h7F92_0000, 4'h4);
    expect_store(32'h253, 32'h9200_0000, 4'h8);
    expect_store(32'h254, 32'h80F1_7F92, 4'h3);
    expect_store(32'h256, 32'h7F92_0000, 4'hC);
    expect_store(32'h258, 32'h0000_0005, 4'hF);
    expect_store(32'h25C, 32'h0000_0118, 4'hF);
    expect_store(32'h260, 32'h0000_0128, 4'hF);
    expect_store(32'h264, 32'h0000_0000, 4'hF);
    expect_store(32'h268, 32'h0000_0005, 4'hF);
    expect_store(32'h144, 32'h0, 4'h0);    // Loop address on ibus_addr
endtask

//--- tb_rv_core.sv
// Testbench for the multi-cycle RV32I core
// Bus models answer after 0 to 3 random wait cycles
// Data memory covers byte addresses 0x000 to 0x3FF
`include "rv_cfg.svh"

module tb_rv_core;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        ibus_req, ibus_ready;
    logic [31:0] ibus_addr, ibus_rdata;
    logic        dbus_req, dbus_we, dbus_ready;
    logic [31:0] dbus_addr, dbus_wdata, dbus_rdata;
    logic [3:0]  dbus_wstrb;

    logic [31:0] rom [0:127];
    logic [31:0] dmem [0:255];
    int          rom_fill;
    int          errors;
    int          i_wait, d_wait;
    logic        i_pend, d_pend, first_seen;
    logic [31:0] i_held, d_held;

    logic [31:0] exp_addr[$], exp_data[$];
    logic [3:0]  exp_strb[$];
    logic [31:0] st_addr[$], st_data[$];
    logic [3:0]  st_strb[$];

    `include "tb_program.svh"

    rv_core dut (
        .clk(clk), .rst_n(rst_n),
        .ibus_req(ibus_req), .ibus_addr(ibus_addr),
        .ibus_rdata(ibus_rdata), .ibus_ready(ibus_ready),
        .dbus_req(dbus_req), .dbus_we(dbus_we), .dbus_addr(dbus_addr),
        .dbus_wdata(dbus_wdata), .dbus_wstrb(dbus_wstrb),
        .dbus_rdata(dbus_rdata), .dbus_ready(dbus_ready)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    initial begin
        forever #2 clk = ~clk;
    end

    // ==============================
    // Bus models
    // ==============================
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ibus_ready) begin
                ibus_ready = 1'b0;           // Transfer done at this edge
            end else if (ibus_req) begin
                if (i_wait == 0) begin
                    ibus_rdata = rom[ibus_addr[8:2]];
                    ibus_ready = 1'b1;
                    i_wait     = $urandom % 4;
                end else begin
                    i_wait--;
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (dbus_ready) begin
                dbus_ready = 1'b0;
            end else if (dbus_req) begin
                if (d_wait == 0) begin
                    dbus_rdata = dmem[dbus_addr[9:2]];
                    dbus_ready = 1'b1;
                    d_wait     = $urandom % 4;
                end else begin
                    d_wait--;
                end
            end
        end
    end

    // Monitors sample mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("ibus_req in reset", 32'd0, {31'd0, ibus_req});
            check_value("dbus_req in reset", 32'd0, {31'd0, dbus_req});
        end
        if (ibus_req) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                check_value("first fetch", `RV_RESET_PC, ibus_addr);
            end
            check_value("ibus_addr align", 32'd0, {30'd0, ibus_addr[1:0]});
            if (i_pend) check_value("ibus_addr hold", i_held, ibus_addr);
            i_pend = !ibus_ready;
            i_held = ibus_addr;
        end else begin
            i_pend = 1'b0;
        end
        if (dbus_req) begin
            if (d_pend) check_value("dbus_addr hold", d_held, dbus_addr);
            d_pend = !dbus_ready;
            d_held = dbus_addr;
            if (dbus_ready && dbus_we) begin
                st_addr.push_back(dbus_addr);
                st_data.push_back(dbus_wdata);
                st_strb.push_back(dbus_wstrb);
                for (int k = 0; k < 4; k++) begin
                    if (dbus_wstrb[k]) dmem[dbus_addr[9:2]][8*k +: 8] = dbus_wdata[8*k +: 8];
                end
            end
        end else begin
            d_pend = 1'b0;
        end
    end

    // Watchdog, 12 cycles of 4 units per table entry with 4x margin
    initial begin
        @(posedge rst_n);
        #(exp_addr.size() * 12 * 4 * 4);
        $display("Timeout: the program did not reach its final loop in time");
        $display("Checks failed: %0d", errors);
        $display("Done: errors found");
        $finish;
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int n;
        void'($urandom(58328));
        rst_n      = 1'b0;
        ibus_ready = 1'b0;
        ibus_rdata = '0;
        dbus_ready = 1'b0;
        dbus_rdata = '0;
        errors     = 0;
        i_wait     = 0;
        d_wait     = 0;
        i_pend     = 1'b0;
        d_pend     = 1'b0;
        first_seen = 1'b0;
        load_program();
        load_expected();
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        n = exp_addr.size();
        for (int t = 0; t < n - 1; t++) begin
            while (st_addr.size() == 0) @(negedge clk);
            check_value($sformatf("store %0d addr", t), exp_addr[t], st_addr.pop_front());
            check_value($sformatf("store %0d data", t), exp_data[t], st_data.pop_front());
            check_value($sformatf("store %0d strb", t), {28'd0, exp_strb[t]},
                        {28'd0, st_strb.pop_front()});
        end
        // Last entry is the self loop fetch address
        while (!(ibus_req && ibus_addr == exp_addr[n-1])) @(negedge clk);
        check_value("extra stores", 32'd0, st_addr.size());

        $display("Checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
rv_pkg.sv
core_sequencer.sv
instr_fetch.sv
instr_decode.sv
register_file.sv
execute_stage.sv
mem_access.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
# Verilator build and run of the RV32I core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary -f src.f --top-module tb_rv_core -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
